/* source/procPkg.sv */
/*
 * Shared widths, opcodes and types for the 16-bit pipelined processor.
 * Every RTL file and the testbench refer to these by scoped name.
 */
`default_nettype none

package procPkg;

   localparam int WordWidth = 16;
   localparam int MemWords = 256;
   localparam int AddrWidth = $clog2(MemWords);
   localparam int RegCount = 8;

   typedef logic [WordWidth-1:0] word;
   typedef logic [2:0] regAddr;
   typedef logic [AddrWidth-1:0] memAddr;
   typedef logic [4:0] opcode;

   // Opcode sits in instruction bits 15 to 11
   localparam opcode OpNop = 5'd0;
   localparam opcode OpHalt = 5'd1;
   localparam opcode OpAdd = 5'd2;
   localparam opcode OpSub = 5'd3;
   localparam opcode OpAnd = 5'd4;
   localparam opcode OpXor = 5'd5;
   localparam opcode OpAddi = 5'd6;
   localparam opcode OpLbi = 5'd7;
   localparam opcode OpLd = 5'd8;
   localparam opcode OpSt = 5'd9;
   localparam opcode OpBeqz = 5'd10;
   localparam opcode OpBnez = 5'd11;
   localparam opcode OpJ = 5'd12;

   typedef enum logic [2:0] {
      AluAdd,
      AluSub,
      AluAnd,
      AluXor,
      AluPassB
   } aluOp;

   typedef enum logic [1:0] {
      FwdNone,
      FwdExMem,
      FwdMemWb
   } fwdSel;

endpackage

`default_nettype wire

/* source/fetch.sv */
/*
 * Instruction fetch. Holds the program counter and requests the word at
 * it from the shared memory. Advances only on a grant while not stalled,
 * jumps on redirect, and stops for good once a halt is seen.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch (
   input logic clk,
   input logic reset,
   input logic run,
   input logic stall,
   input logic redirect,
   input procPkg::word redirectPc,
   input logic freeze,
   input logic fetchGrant,
   input procPkg::word fetchRdData,
   output logic fetchReq,
   output procPkg::memAddr fetchAddr,
   output procPkg::word instr,
   output procPkg::word pcNext,
   output logic instrValid
);

   procPkg::word pc;
   logic frozen;

   assign fetchReq = run && !frozen && !freeze;
   assign fetchAddr = pc[procPkg::AddrWidth-1:0];
   assign pcNext = pc + 1'b1;

   // Memory data only belongs to fetch in a granted cycle
   assign instr = fetchRdData;
   assign instrValid = fetchGrant;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         frozen <= 1'b0;
      end else begin
         if (freeze)
            frozen <= 1'b1;
         if (redirect)
            pc <= redirectPc;
         else if (fetchGrant && !stall)
            pc <= pcNext;
      end
   end

endmodule

`default_nettype wire

/* source/decode.sv */
/*
 * Decode stage. Splits the instruction fields, generates control for each
 * opcode, flags illegal codes and holds the eight-entry register file.
 * Writeback lands at the clock edge; reads see a same-cycle write.
 */
`timescale 1ns/1ps
`default_nettype none

module decode (
   input logic clk,
   input logic reset,
   input procPkg::word instr,
   input logic instrValid,
   input logic wbEn,
   input procPkg::regAddr wbAddr,
   input procPkg::word wbData,
   output procPkg::regAddr rsAddr,
   output procPkg::regAddr rtAddr,
   output procPkg::regAddr destAddr,
   output procPkg::word rsData,
   output procPkg::word rtData,
   output procPkg::word imm,
   output procPkg::aluOp op,
   output logic useImm,
   output logic regWrite,
   output logic memRead,
   output logic memWrite,
   output logic isBranch,
   output logic branchOnZero,
   output logic isJump,
   output logic isHalt,
   output logic illegal
);

   procPkg::word regs [procPkg::RegCount];
   procPkg::opcode code;
   logic rType;
   logic legal;

   assign code = instr[15:11];
   assign rsAddr = instr[10:8];
   assign rtAddr = instr[7:5];
   assign rType = code inside {procPkg::OpAdd, procPkg::OpSub, procPkg::OpAnd, procPkg::OpXor};
   assign legal = code <= procPkg::OpJ;

   // Write-first bypass
   assign rsData = (wbEn && wbAddr == rsAddr) ? wbData : regs[rsAddr];
   assign rtData = (wbEn && wbAddr == rtAddr) ? wbData : regs[rtAddr];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < procPkg::RegCount; i++)
            regs[i] <= '0;
      end else if (wbEn) begin
         regs[wbAddr] <= wbData;
      end
   end

   always_comb begin
      case (code)
         procPkg::OpSub: op = procPkg::AluSub;
         procPkg::OpAnd: op = procPkg::AluAnd;
         procPkg::OpXor: op = procPkg::AluXor;
         procPkg::OpLbi: op = procPkg::AluPassB;
         default: op = procPkg::AluAdd;
      endcase
   end

   always_comb begin
      useImm = !rType;
      destAddr = rType ? instr[4:2] : instr[7:5];
      imm = {{11{instr[4]}}, instr[4:0]};
      regWrite = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      branchOnZero = 1'b0;
      isJump = 1'b0;
      isHalt = 1'b0;
      illegal = instrValid && !legal;
      // A bubble leaves every control low
      if (instrValid) begin
         case (code)
            procPkg::OpHalt: isHalt = 1'b1;
            procPkg::OpAdd, procPkg::OpSub, procPkg::OpAnd, procPkg::OpXor,
            procPkg::OpAddi: regWrite = 1'b1;
            procPkg::OpLbi: begin
               regWrite = 1'b1;
               destAddr = instr[10:8];
               imm = {{8{instr[7]}}, instr[7:0]};
            end
            procPkg::OpLd: begin
               regWrite = 1'b1;
               memRead = 1'b1;
            end
            procPkg::OpSt: memWrite = 1'b1;
            procPkg::OpBeqz, procPkg::OpBnez: begin
               isBranch = 1'b1;
               branchOnZero = code == procPkg::OpBeqz;
               imm = {{8{instr[7]}}, instr[7:0]};
            end
            procPkg::OpJ: begin
               isJump = 1'b1;
               imm = {{5{instr[10]}}, instr[10:0]};
            end
            default: isHalt = 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/execute.sv */
/*
 * Execute stage. Picks forwarded operands, runs the ALU for results and
 * memory addresses, and resolves branches and jumps against pcNext.
 */
`timescale 1ns/1ps
`default_nettype none

module execute (
   input procPkg::aluOp op,
   input logic useImm,
   input procPkg::word rsData,
   input procPkg::word rtData,
   input procPkg::word imm,
   input procPkg::word exMemData,
   input procPkg::word memWbData,
   input procPkg::fwdSel fwdA,
   input procPkg::fwdSel fwdB,
   input logic isBranch,
   input logic branchOnZero,
   input logic isJump,
   input procPkg::word pcNext,
   output procPkg::word aluOut,
   output procPkg::word storeData,
   output procPkg::word redirectPc,
   output logic redirect
);

   procPkg::word opA;
   procPkg::word opB;
   logic taken;

   function automatic procPkg::word forward(input procPkg::fwdSel sel,
                                            input procPkg::word regVal);
      case (sel)
         procPkg::FwdExMem: return exMemData;
         procPkg::FwdMemWb: return memWbData;
         default: return regVal;
      endcase
   endfunction

   assign opA = forward(fwdA, rsData);
   assign storeData = forward(fwdB, rtData);
   assign opB = useImm ? imm : storeData;

   always_comb begin
      case (op)
         procPkg::AluSub: aluOut = opA - opB;
         procPkg::AluAnd: aluOut = opA & opB;
         procPkg::AluXor: aluOut = opA ^ opB;
         procPkg::AluPassB: aluOut = opB;
         default: aluOut = opA + opB;
      endcase
   end

   // Branches test Rs against zero
   assign taken = isBranch && ((opA == '0) == branchOnZero);
   assign redirect = isJump || taken;
   assign redirectPc = pcNext + imm;

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
/*
 * Hazard detection. Chooses forwarding sources for the operands in
 * execute, newest producer first, and stalls decode on a load-use pair.
 */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
   input procPkg::regAddr idRs,
   input procPkg::regAddr idRt,
   input procPkg::regAddr exRs,
   input procPkg::regAddr exRt,
   input procPkg::regAddr exDest,
   input procPkg::regAddr memDest,
   input procPkg::regAddr wbDest,
   input logic exMemRead,
   input logic memRegWrite,
   input logic wbRegWrite,
   output procPkg::fwdSel fwdA,
   output procPkg::fwdSel fwdB,
   output logic loadStall
);

   always_comb begin
      if (memRegWrite && memDest == exRs)
         fwdA = procPkg::FwdExMem;
      else if (wbRegWrite && wbDest == exRs)
         fwdA = procPkg::FwdMemWb;
      else
         fwdA = procPkg::FwdNone;
   end

   always_comb begin
      if (memRegWrite && memDest == exRt)
         fwdB = procPkg::FwdExMem;
      else if (wbRegWrite && wbDest == exRt)
         fwdB = procPkg::FwdMemWb;
      else
         fwdB = procPkg::FwdNone;
   end

   // Loaded data is not ready until the load reaches MEM/WB
   assign loadStall = exMemRead && (exDest == idRs || exDest == idRt);

endmodule

`default_nettype wire

/* source/memArbiter.sv */
/*
 * Shared 256-word memory with a fixed-priority arbiter in front of it.
 * Priority is host, then the data stage, then fetch. Reads are
 * combinational; a granted write lands at the clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
   input logic clk,
   input logic reset,
   input logic hostReq,
   input logic hostWrite,
   input procPkg::memAddr hostAddr,
   input procPkg::word hostWrData,
   input logic dataReq,
   input logic dataWrite,
   input procPkg::memAddr dataAddr,
   input procPkg::word dataWrData,
   input logic fetchReq,
   input procPkg::memAddr fetchAddr,
   output logic hostGrant,
   output logic dataGrant,
   output logic fetchGrant,
   output procPkg::word rdData
);

   procPkg::word mem [procPkg::MemWords];
   procPkg::memAddr addr;
   procPkg::word wrData;
   logic wrEn;

   assign hostGrant = hostReq;
   assign dataGrant = dataReq && !hostReq;
   assign fetchGrant = fetchReq && !hostReq && !dataReq;

   always_comb begin
      if (hostReq)
         addr = hostAddr;
      else if (dataReq)
         addr = dataAddr;
      else
         addr = fetchAddr;
   end

   assign wrEn = (hostGrant && hostWrite) || (dataGrant && dataWrite);
   assign wrData = hostReq ? hostWrData : dataWrData;
   assign rdData = mem[addr];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < procPkg::MemWords; i++)
            mem[i] <= '0;
      end else if (wrEn) begin
         mem[addr] <= wrData;
      end
   end

endmodule

`default_nettype wire

/* source/proc.sv */
/*
 * Top level of the five-stage processor. Holds the IF/ID, ID/EX, EX/MEM
 * and MEM/WB registers, the writeback mux and the sticky halted and err
 * flags. The host port shares memory with the pipeline at top priority.
 */
`timescale 1ns/1ps
`default_nettype none

module proc (
   input logic clk,
   input logic reset,
   input logic run,
   input logic hostReq,
   input logic hostWrite,
   input procPkg::memAddr hostAddr,
   input procPkg::word hostWrData,
   output procPkg::word hostRdData,
   output logic hostGrant,
   output logic halted,
   output logic err
);

   // Fetch and memory
   logic fetchReq, fetchGrant, instrValid, dataGrant, dataReq;
   procPkg::memAddr fetchAddr;
   procPkg::word fetchInstr, fetchPcNext, memRdData;

   // Decode outputs
   procPkg::regAddr decRs, decRt, decDest;
   procPkg::word decRsData, decRtData, decImm;
   procPkg::aluOp decOp;
   logic decUseImm, decRegWrite, decMemRead, decMemWrite;
   logic decIsBranch, decBranchOnZero, decIsJump, decIsHalt, decIllegal;

   // Hazards and execute
   procPkg::fwdSel fwdA, fwdB;
   logic loadStall, memStall, takeRedirect, freeze, exRedirect;
   procPkg::word exAlu, exStore, exTarget, wbData;

   // IF/ID
   procPkg::word ifIdInstr, ifIdPcNext;
   logic ifIdValid;

   // ID/EX
   procPkg::regAddr idExRs, idExRt, idExDest;
   procPkg::word idExRsData, idExRtData, idExImm, idExPcNext;
   procPkg::aluOp idExOp;
   logic idExUseImm, idExRegWrite, idExMemRead, idExMemWrite;
   logic idExIsBranch, idExBranchOnZero, idExIsJump, idExHalt, idExIllegal;

   // EX/MEM
   procPkg::regAddr exMemDest;
   procPkg::word exMemAlu, exMemStore;
   logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemHalt, exMemIllegal;

   // MEM/WB
   procPkg::regAddr memWbDest;
   procPkg::word memWbAlu, memWbLoad;
   logic memWbRegWrite, memWbMemRead, memWbHalt, memWbIllegal;

   // A data access losing to the host holds every stage
   assign dataReq = exMemMemRead || exMemMemWrite;
   assign memStall = dataReq && !dataGrant;
   assign takeRedirect = exRedirect && !memStall;
   // A wrong-path halt behind a redirecting branch must not freeze fetch
   assign freeze = ((decIsHalt || decIllegal) && !exRedirect) || halted;
   assign wbData = memWbMemRead ? memWbLoad : memWbAlu;
   assign hostRdData = memRdData;

   fetch fetchStage (
      .clk(clk), .reset(reset), .run(run), .stall(loadStall || memStall),
      .redirect(takeRedirect), .redirectPc(exTarget), .freeze(freeze),
      .fetchGrant(fetchGrant), .fetchRdData(memRdData), .fetchReq(fetchReq),
      .fetchAddr(fetchAddr), .instr(fetchInstr), .pcNext(fetchPcNext),
      .instrValid(instrValid)
   );

   always_ff @(posedge clk) begin
      if (reset || takeRedirect) begin
         ifIdValid <= 1'b0;
      end else if (!memStall && !loadStall) begin
         ifIdValid <= instrValid;
         ifIdInstr <= fetchInstr;
         ifIdPcNext <= fetchPcNext;
      end
   end

   decode decodeStage (
      .clk(clk), .reset(reset), .instr(ifIdInstr), .instrValid(ifIdValid),
      .wbEn(memWbRegWrite), .wbAddr(memWbDest), .wbData(wbData),
      .rsAddr(decRs), .rtAddr(decRt), .destAddr(decDest), .rsData(decRsData),
      .rtData(decRtData), .imm(decImm), .op(decOp), .useImm(decUseImm),
      .regWrite(decRegWrite), .memRead(decMemRead), .memWrite(decMemWrite),
      .isBranch(decIsBranch), .branchOnZero(decBranchOnZero), .isJump(decIsJump),
      .isHalt(decIsHalt), .illegal(decIllegal)
   );

   hazardUnit hazards (
      .idRs(decRs), .idRt(decRt), .exRs(idExRs), .exRt(idExRt), .exDest(idExDest),
      .memDest(exMemDest), .wbDest(memWbDest), .exMemRead(idExMemRead),
      .memRegWrite(exMemRegWrite), .wbRegWrite(memWbRegWrite),
      .fwdA(fwdA), .fwdB(fwdB), .loadStall(loadStall)
   );

   always_ff @(posedge clk) begin
      if (reset || takeRedirect || (loadStall && !memStall)) begin
         idExRegWrite <= 1'b0;
         idExMemRead <= 1'b0;
         idExMemWrite <= 1'b0;
         idExIsBranch <= 1'b0;
         idExIsJump <= 1'b0;
         idExHalt <= 1'b0;
         idExIllegal <= 1'b0;
      end else if (!memStall) begin
         idExRs <= decRs;
         idExRt <= decRt;
         idExDest <= decDest;
         idExRsData <= decRsData;
         idExRtData <= decRtData;
         idExImm <= decImm;
         idExPcNext <= ifIdPcNext;
         idExOp <= decOp;
         idExUseImm <= decUseImm;
         idExBranchOnZero <= decBranchOnZero;
         idExRegWrite <= decRegWrite;
         idExMemRead <= decMemRead;
         idExMemWrite <= decMemWrite;
         idExIsBranch <= decIsBranch;
         idExIsJump <= decIsJump;
         idExHalt <= decIsHalt;
         idExIllegal <= decIllegal;
      end
   end

   execute executeStage (
      .op(idExOp), .useImm(idExUseImm), .rsData(idExRsData), .rtData(idExRtData),
      .imm(idExImm), .exMemData(exMemAlu), .memWbData(wbData), .fwdA(fwdA),
      .fwdB(fwdB), .isBranch(idExIsBranch), .branchOnZero(idExBranchOnZero),
      .isJump(idExIsJump), .pcNext(idExPcNext), .aluOut(exAlu),
      .storeData(exStore), .redirectPc(exTarget), .redirect(exRedirect)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         exMemRegWrite <= 1'b0;
         exMemMemRead <= 1'b0;
         exMemMemWrite <= 1'b0;
         exMemHalt <= 1'b0;
         exMemIllegal <= 1'b0;
      end else if (!memStall) begin
         exMemDest <= idExDest;
         exMemAlu <= exAlu;
         exMemStore <= exStore;
         exMemRegWrite <= idExRegWrite;
         exMemMemRead <= idExMemRead;
         exMemMemWrite <= idExMemWrite;
         exMemHalt <= idExHalt;
         exMemIllegal <= idExIllegal;
      end
   end

   memArbiter arbiter (
      .clk(clk), .reset(reset), .hostReq(hostReq), .hostWrite(hostWrite),
      .hostAddr(hostAddr), .hostWrData(hostWrData), .dataReq(dataReq),
      .dataWrite(exMemMemWrite), .dataAddr(exMemAlu[procPkg::AddrWidth-1:0]),
      .dataWrData(exMemStore), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
      .hostGrant(hostGrant), .dataGrant(dataGrant), .fetchGrant(fetchGrant),
      .rdData(memRdData)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         memWbRegWrite <= 1'b0;
         memWbMemRead <= 1'b0;
         memWbHalt <= 1'b0;
         memWbIllegal <= 1'b0;
      end else if (!memStall) begin
         memWbDest <= exMemDest;
         memWbAlu <= exMemAlu;
         memWbLoad <= memRdData;
         memWbRegWrite <= exMemRegWrite;
         memWbMemRead <= exMemMemRead;
         memWbHalt <= exMemHalt;
         memWbIllegal <= exMemIllegal;
      end
   end

   // Sticky until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         if (memWbHalt || memWbIllegal)
            halted <= 1'b1;
         if (memWbIllegal)
            err <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* test/proc_asserts.sv */
/*
 * Concurrent checks on the shared-memory grants and on the sticky
 * halted and err flags. Bound into every proc instance.
 */
`timescale 1ns/1ps
`default_nettype none

module proc_asserts (
   input logic clk,
   input logic reset,
   input logic hostReq,
   input logic dataReq,
   input logic fetchReq,
   input logic hostGrant,
   input logic dataGrant,
   input logic fetchGrant,
   input logic halted,
   input logic err
);

   // One peer owns the memory at a time
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({hostGrant, dataGrant, fetchGrant}))
      else $error("More than one memory grant in a cycle");

   assert property (@(posedge clk) disable iff (reset)
      (!hostGrant || hostReq) && (!dataGrant || dataReq) && (!fetchGrant || fetchReq))
      else $error("Memory grant without a request");

   assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else $error("halted dropped before reset");

   assert property (@(posedge clk) disable iff (reset) err |=> err)
      else $error("err dropped before reset");

   assert property (@(posedge clk) disable iff (reset) err |-> halted)
      else $error("err set while not halted");

endmodule

bind proc proc_asserts procChecks (
   .clk(clk), .reset(reset), .hostReq(hostReq), .dataReq(dataReq), .fetchReq(fetchReq),
   .hostGrant(hostGrant), .dataGrant(dataGrant), .fetchGrant(fetchGrant),
   .halted(halted), .err(err)
);

`default_nettype wire

/* test/procTb.sv */
/*
 * Directed testbench for the pipelined processor. Each test resets the
 * DUT, loads a program over the host port, runs it until halted and
 * checks memory and flags against values worked out from the ISA rules.
 */
`timescale 1ns/1ps
`default_nettype none

module procTb;

   logic clk = 1'b0;
   logic reset;
   logic run;
   logic hostReq;
   logic hostWe;
   procPkg::memAddr hostAddr;
   procPkg::word hostWrData;
   procPkg::word hostRdData;
   logic hostGrant;
   logic halted;
   logic err;
   int errors;
   procPkg::word prog [$];

   proc DUT (
      .clk(clk), .reset(reset), .run(run), .hostReq(hostReq), .hostWrite(hostWe),
      .hostAddr(hostAddr), .hostWrData(hostWrData), .hostRdData(hostRdData),
      .hostGrant(hostGrant), .halted(halted), .err(err)
   );

   always #5 clk = ~clk;

   function automatic procPkg::word signExtend8(input logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic procPkg::word signExtend5(input logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   // Instruction encoders
   function automatic procPkg::word encodeR(input procPkg::opcode code, input procPkg::regAddr rs,
                                            input procPkg::regAddr rt, input procPkg::regAddr rd);
      return {code, rs, rt, rd, 2'b00};
   endfunction

   function automatic procPkg::word encodeI(input procPkg::opcode code, input procPkg::regAddr rs,
                                            input procPkg::regAddr rt, input logic [4:0] imm);
      return {code, rs, rt, imm};
   endfunction

   function automatic procPkg::word encodeWide(input procPkg::opcode code,
                                               input logic [10:0] field);
      return {code, field};
   endfunction

   function automatic procPkg::word encodeLbi(input procPkg::regAddr rs, input logic [7:0] imm);
      return encodeWide(procPkg::OpLbi, {rs, imm});
   endfunction

   task automatic abortRun();
      errors++;
      $display("TESTS FAILED");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic checkWord(input string name, input procPkg::word got, input procPkg::word want);
      if (got !== want) begin
         $display("ERR %0t %s expected %h got %h", $time, name, want, got);
         abortRun();
      end
   endtask

   task automatic checkFlag(input string name, input bit got, input bit want);
      if (got !== want) begin
         $display("ERR %0t %s expected %b got %b", $time, name, want, got);
         abortRun();
      end
   endtask

   task automatic waitHostGrant();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!hostGrant && cycles < 20);
      if (!hostGrant) begin
         $display("Host port was never granted the memory");
         abortRun();
      end
   endtask

   task automatic hostWrite(input procPkg::memAddr addr, input procPkg::word data);
      @(negedge clk);
      hostReq = 1'b1;
      hostWe = 1'b1;
      hostAddr = addr;
      hostWrData = data;
      waitHostGrant();
      @(negedge clk);
      hostReq = 1'b0;
      hostWe = 1'b0;
   endtask

   task automatic hostRead(input procPkg::memAddr addr, output procPkg::word data);
      @(negedge clk);
      hostReq = 1'b1;
      hostWe = 1'b0;
      hostAddr = addr;
      waitHostGrant();
      data = hostRdData;
      @(negedge clk);
      hostReq = 1'b0;
   endtask

   task automatic checkMem(input procPkg::memAddr addr, input procPkg::word want);
      procPkg::word got;
      hostRead(addr, got);
      checkWord($sformatf("mem[%0d]", addr), got, want);
   endtask

   task automatic applyReset();
      @(negedge clk);
      reset = 1'b1;
      run = 1'b0;
      hostReq = 1'b0;
      hostWe = 1'b0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      prog.delete();
   endtask

   task automatic emit(input procPkg::word instr, input int pad);
      prog.push_back(instr);
      repeat (pad) prog.push_back(encodeWide(procPkg::OpNop, 11'd0));
   endtask

   task automatic runUntilHalt();
      int cycles;
      cycles = 0;
      @(negedge clk);
      run = 1'b1;
      while (!halted && cycles < 2000) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("Timed out after %0d cycles waiting for halted", cycles);
         abortRun();
      end
      run = 1'b0;
   endtask

   task automatic loadAndRun();
      foreach (prog[i])
         hostWrite(8'(i), prog[i]);
      runUntilHalt();
   endtask

   task automatic testArithmetic();
      logic [7:0] a;
      logic [7:0] b;
      logic [4:0] k;
      procPkg::word want [5];
      procPkg::opcode ops [4];
      a = 8'($urandom);
      b = 8'($urandom);
      k = 5'($urandom);
      ops = '{procPkg::OpAdd, procPkg::OpSub, procPkg::OpAnd, procPkg::OpXor};
      want[0] = signExtend8(a) + signExtend8(b);
      want[1] = signExtend8(a) - signExtend8(b);
      want[2] = signExtend8(a) & signExtend8(b);
      want[3] = signExtend8(a) ^ signExtend8(b);
      want[4] = signExtend8(a) + signExtend5(k);
      applyReset();
      emit(encodeLbi(3'd1, a), 0);
      emit(encodeLbi(3'd2, b), 0);
      emit(encodeLbi(3'd6, 8'd64), 0);
      foreach (ops[i]) begin
         emit(encodeR(ops[i], 3'd1, 3'd2, 3'd3), 0);
         emit(encodeI(procPkg::OpSt, 3'd6, 3'd3, 5'(i)), 0);
      end
      emit(encodeI(procPkg::OpAddi, 3'd1, 3'd4, k), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd4, 5'd4), 0);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      loadAndRun();
      checkFlag("err", err, 1'b0);
      for (int i = 0; i < 5; i++)
         checkMem(8'(64 + i), want[i]);
   endtask

   // Dependent chain with operands one and two instructions apart
   task automatic runChain(input int pad, input logic [7:0] a, input logic [7:0] b,
                           output procPkg::word r3, output procPkg::word r4,
                           output procPkg::word r5);
      applyReset();
      emit(encodeLbi(3'd1, a), pad);
      emit(encodeLbi(3'd2, b), pad);
      emit(encodeLbi(3'd6, 8'd64), pad);
      emit(encodeR(procPkg::OpAdd, 3'd1, 3'd2, 3'd3), pad);
      emit(encodeR(procPkg::OpSub, 3'd3, 3'd1, 3'd4), pad);
      emit(encodeR(procPkg::OpXor, 3'd3, 3'd4, 3'd5), pad);
      emit(encodeR(procPkg::OpAnd, 3'd5, 3'd4, 3'd3), pad);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd3, 5'd0), pad);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd4, 5'd1), pad);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd5, 5'd2), pad);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      loadAndRun();
      hostRead(8'd64, r3);
      hostRead(8'd65, r4);
      hostRead(8'd66, r5);
   endtask

   task automatic testForwarding();
      logic [7:0] a;
      logic [7:0] b;
      procPkg::word sum;
      procPkg::word diff;
      procPkg::word tight [3];
      procPkg::word padded [3];
      a = 8'($urandom);
      b = 8'($urandom);
      sum = signExtend8(a) + signExtend8(b);
      diff = sum - signExtend8(a);
      runChain(0, a, b, tight[0], tight[1], tight[2]);
      runChain(3, a, b, padded[0], padded[1], padded[2]);
      for (int i = 0; i < 3; i++)
         checkWord($sformatf("forwarded store %0d", i), tight[i], padded[i]);
      checkWord("chain AND result", tight[0], (sum ^ diff) & diff);
      checkWord("chain SUB result", tight[1], diff);
      checkWord("chain XOR result", tight[2], sum ^ diff);
   endtask

   task automatic testLoadUse();
      procPkg::word d;
      logic [7:0] c;
      d = 16'($urandom);
      c = 8'($urandom);
      applyReset();
      hostWrite(8'd100, d);
      emit(encodeLbi(3'd6, 8'd100), 0);
      emit(encodeLbi(3'd2, c), 0);
      emit(encodeI(procPkg::OpLd, 3'd6, 3'd1, 5'd0), 0);
      emit(encodeR(procPkg::OpAdd, 3'd1, 3'd2, 3'd3), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd3, 5'd1), 0);
      emit(encodeI(procPkg::OpLd, 3'd6, 3'd4, 5'd0), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd4, 5'd2), 0);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      loadAndRun();
      checkMem(8'd101, d + signExtend8(c));
      checkMem(8'd102, d);
   endtask

   task automatic testControlFlow();
      logic [7:0] mark;
      logic [7:0] ranMask;
      mark = 8'($urandom) | 8'h01;
      // Marker slots 2, 3, 4 and 7 sit on the executed path
      ranMask = 8'b1001_1100;
      applyReset();
      emit(encodeLbi(3'd6, 8'd64), 0);
      emit(encodeLbi(3'd1, 8'd0), 0);
      emit(encodeLbi(3'd7, mark), 0);
      emit(encodeWide(procPkg::OpBeqz, {3'd1, 8'd2}), 0);
      for (int i = 0; i < 3; i++)
         emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'(i)), 0);
      emit(encodeWide(procPkg::OpBnez, {3'd1, 8'd2}), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'd3), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'd4), 0);
      emit(encodeWide(procPkg::OpJ, 11'd2), 0);
      for (int i = 5; i < 8; i++)
         emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'(i)), 0);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      loadAndRun();
      for (int i = 0; i < 8; i++)
         checkMem(8'(64 + i), ranMask[i] ? signExtend8(mark) : 16'h0000);
   endtask

   task automatic testHostPriority();
      logic [7:0] v;
      procPkg::word got;
      procPkg::word hostWords [8];
      v = 8'($urandom);
      applyReset();
      emit(encodeLbi(3'd6, 8'd64), 0);
      emit(encodeLbi(3'd1, 8'd8), 0);
      emit(encodeLbi(3'd2, v), 0);
      // Loop body starts at word 3 and makes eight passes
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd2, 5'd0), 0);
      emit(encodeI(procPkg::OpAddi, 3'd6, 3'd6, 5'd1), 0);
      emit(encodeI(procPkg::OpAddi, 3'd2, 3'd2, 5'd3), 0);
      emit(encodeI(procPkg::OpAddi, 3'd1, 3'd1, 5'h1f), 0);
      emit(encodeWide(procPkg::OpBnez, {3'd1, 8'hfb}), 0);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      foreach (prog[i])
         hostWrite(8'(i), prog[i]);
      fork
         runUntilHalt();
         for (int i = 0; i < 8; i++) begin
            hostWords[i] = 16'($urandom);
            hostWrite(8'(128 + i), hostWords[i]);
            hostRead(8'(128 + i), got);
            checkWord("host readback", got, hostWords[i]);
            hostRead(8'(64 + i), got);
            // A loop slot is either still clear or holds its final store
            if (got !== 16'h0000 && got !== signExtend8(v) + 16'(3 * i)) begin
               $display("Host read of loop slot %0d returned a word the program never stores",
                        i);
               abortRun();
            end
         end
      join
      checkFlag("halted", halted, 1'b1);
      for (int i = 0; i < 8; i++) begin
         checkMem(8'(64 + i), signExtend8(v) + 16'(3 * i));
         checkMem(8'(128 + i), hostWords[i]);
      end
   endtask

   task automatic testHaltAndIllegal();
      logic [7:0] mark;
      mark = 8'($urandom) | 8'h01;
      applyReset();
      checkFlag("halted", halted, 1'b0);
      checkFlag("err", err, 1'b0);
      checkFlag("hostGrant", hostGrant, 1'b0);
      emit(encodeLbi(3'd6, 8'd64), 0);
      emit(encodeLbi(3'd7, mark), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'd0), 0);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      loadAndRun();
      checkFlag("err", err, 1'b0);
      checkMem(8'd64, signExtend8(mark));
      // Same start followed by an unused opcode ahead of two stores
      applyReset();
      emit(encodeLbi(3'd6, 8'd64), 0);
      emit(encodeLbi(3'd7, mark), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'd0), 0);
      emit(encodeWide(5'h1f, 11'd0), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'd1), 0);
      emit(encodeI(procPkg::OpSt, 3'd6, 3'd7, 5'd2), 0);
      emit(encodeWide(procPkg::OpHalt, 11'd0), 0);
      loadAndRun();
      checkFlag("err", err, 1'b1);
      checkMem(8'd64, signExtend8(mark));
      checkMem(8'd65, 16'h0000);
      checkMem(8'd66, 16'h0000);
   endtask

   initial begin
      reset = 1'b1;
      run = 1'b0;
      hostReq = 1'b0;
      hostWe = 1'b0;
      hostAddr = '0;
      hostWrData = '0;
      errors = 0;
      void'($urandom(32'hddf4));
      testArithmetic();
      testForwarding();
      testLoadUse();
      testControlFlow();
      testHostPriority();
      testHaltAndIllegal();
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* proc.f */
source/procPkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/hazardUnit.sv
source/memArbiter.sv
source/proc.sv
test/proc_asserts.sv
test/procTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the processor testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module procTb -f proc.f \
   -o procSim > build.log 2>&1 \
   && ./obj_dir/procSim > sim.log 2>&1 \
   || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -q "^TESTS PASSED$" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
